//--- logic/soc_pkg.sv
`default_nettype none

package soc_pkg;

  localparam int unsigned SocAddrWidth = 64;
  localparam int unsigned SocDataWidth = 64;
  localparam int unsigned SocStrbWidth = SocDataWidth / 8;
  localparam int unsigned ApbDataWidth = 32;

  // Address map
  localparam logic [63:0] DramBase   = 64'h8000_0000;
  localparam logic [63:0] UartBase   = 64'hC000_0000;
  localparam logic [63:0] CtrlBase   = 64'hD000_0000;
  localparam logic [63:0] DramLength = 64'h4000_0000;
  localparam logic [63:0] UartLength = 64'h1000;
  localparam logic [63:0] CtrlLength = 64'h1000;

  typedef enum logic [1:0] {
    REGION_L2   = 2'd0,
    REGION_UART = 2'd1,
    REGION_CTRL = 2'd2,
    REGION_NONE = 2'd3
  } soc_region_e;

  // Register offsets inside the CTRL region
  localparam logic [63:0] CtrlExitOffset    = 64'h0;
  localparam logic [63:0] CtrlHwCntEnOffset = 64'h8;

  // Byte-lane merge of write data into an old word
  function automatic logic [SocDataWidth-1:0] strb_merge(
    input logic [SocDataWidth-1:0] old_word,
    input logic [SocDataWidth-1:0] new_word,
    input logic [SocStrbWidth-1:0] strb
  );
    logic [SocDataWidth-1:0] merged;
    merged = old_word;
    for (int b = 0; b < SocStrbWidth; b++) begin
      if (strb[b]) merged[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- logic/soc_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module soc_addr_decode import soc_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_valid_i,
  input  logic                    req_write_i,
  input  logic [SocAddrWidth-1:0] req_addr_i,
  input  logic [SocDataWidth-1:0] req_wdata_i,
  input  logic [SocStrbWidth-1:0] req_strb_i,
  input  logic                    rsp_taken_i,
  output logic                    req_ready_o,
  output soc_region_e             cmd_region_o,
  output logic                    cmd_write_o,
  output logic [SocAddrWidth-1:0] cmd_offset_o,
  output logic [SocDataWidth-1:0] cmd_wdata_o,
  output logic [SocStrbWidth-1:0] cmd_strb_o,
  output logic                    l2_req_o,
  output logic                    uart_req_o,
  output logic                    ctrl_req_o,
  output logic                    none_start_o
);

  logic                    busy_q;
  logic                    req_fire;
  soc_region_e             region_d;
  logic [SocAddrWidth-1:0] offset_d;

  // Only one request in flight
  assign req_ready_o = ~busy_q;
  assign req_fire    = req_valid_i & req_ready_o;

  always_comb begin
    region_d = REGION_NONE;
    offset_d = req_addr_i;
    if (req_addr_i >= DramBase && req_addr_i < DramBase + DramLength) begin
      region_d = REGION_L2;
      offset_d = req_addr_i - DramBase;
    end else if (req_addr_i >= UartBase && req_addr_i < UartBase + UartLength) begin
      region_d = REGION_UART;
      offset_d = req_addr_i - UartBase;
    end else if (req_addr_i >= CtrlBase && req_addr_i < CtrlBase + CtrlLength) begin
      region_d = REGION_CTRL;
      offset_d = req_addr_i - CtrlBase;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q       <= 1'b0;
      cmd_region_o <= REGION_NONE;
      l2_req_o     <= 1'b0;
      uart_req_o   <= 1'b0;
      ctrl_req_o   <= 1'b0;
      none_start_o <= 1'b0;
    end else begin
      l2_req_o     <= req_fire && region_d == REGION_L2;
      uart_req_o   <= req_fire && region_d == REGION_UART;
      ctrl_req_o   <= req_fire && region_d == REGION_CTRL;
      none_start_o <= req_fire && region_d == REGION_NONE;
      if (req_fire) begin
        busy_q       <= 1'b1;
        cmd_region_o <= region_d;
      end else if (rsp_taken_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      cmd_write_o  <= req_write_i;
      cmd_offset_o <= offset_d;
      cmd_wdata_o  <= req_wdata_i;
      cmd_strb_o   <= req_strb_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/l2_mem.sv
`timescale 1ns/1ps
`default_nettype none

module l2_mem import soc_pkg::*; #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_i,
  input  logic                    write_i,
  input  logic [SocAddrWidth-1:0] offset_i,
  input  logic [SocDataWidth-1:0] wdata_i,
  input  logic [SocStrbWidth-1:0] strb_i,
  output logic                    done_o,
  output logic [SocDataWidth-1:0] rdata_o
);

  localparam int unsigned IdxWidth  = $clog2(L2NumWords);
  localparam int unsigned LaneWidth = $clog2(SocStrbWidth);

  logic [SocDataWidth-1:0] mem_q [L2NumWords];
  logic [IdxWidth-1:0]     word_idx;

  // Word index wraps modulo the memory size
  assign word_idx = offset_i[LaneWidth +: IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        mem_q[word_idx] <= strb_merge(mem_q[word_idx], wdata_i, strb_i);
        rdata_o         <= '0;
      end else begin
        rdata_o <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) done_o <= 1'b0;
    else         done_o <= req_i;
  end

endmodule

`default_nettype wire

//--- logic/apb_uart_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module apb_uart_bridge import soc_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_i,
  input  logic                    write_i,
  input  logic [SocAddrWidth-1:0] offset_i,
  input  logic [SocDataWidth-1:0] wdata_i,
  input  logic [ApbDataWidth-1:0] uart_prdata_i,
  input  logic                    uart_pready_i,
  input  logic                    uart_pslverr_i,
  output logic                    done_o,
  output logic [SocDataWidth-1:0] rdata_o,
  output logic                    err_o,
  output logic                    uart_psel_o,
  output logic                    uart_penable_o,
  output logic                    uart_pwrite_o,
  output logic [31:0]             uart_paddr_o,
  output logic [ApbDataWidth-1:0] uart_pwdata_o
);

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  apb_state_e state_q;
  logic       access_end;

  assign access_end = state_q == APB_ACCESS && uart_pready_i;

  // Command fields stay stable while the request is in flight
  assign uart_psel_o    = state_q != APB_IDLE;
  assign uart_penable_o = state_q == APB_ACCESS;
  assign uart_pwrite_o  = write_i;
  assign uart_paddr_o   = offset_i[31:0];
  assign uart_pwdata_o  = wdata_i[ApbDataWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= APB_IDLE;
      done_o  <= 1'b0;
    end else begin
      done_o <= access_end;
      case (state_q)
        APB_IDLE:   if (req_i) state_q <= APB_SETUP;
        APB_SETUP:  state_q <= APB_ACCESS;
        APB_ACCESS: if (uart_pready_i) state_q <= APB_IDLE;
        default:    state_q <= APB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (access_end) begin
      rdata_o <= write_i ? '0 : {{(SocDataWidth-ApbDataWidth){1'b0}}, uart_prdata_i};
      err_o   <= uart_pslverr_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs import soc_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_i,
  input  logic                    write_i,
  input  logic [SocAddrWidth-1:0] offset_i,
  input  logic [SocDataWidth-1:0] wdata_i,
  input  logic [SocStrbWidth-1:0] strb_i,
  output logic                    done_o,
  output logic [SocDataWidth-1:0] rdata_o,
  output logic                    err_o,
  output logic [63:0]             exit_o,
  output logic [63:0]             hw_cnt_en_o
);

  logic hit_exit;
  logic hit_cnt_en;

  assign hit_exit   = offset_i == CtrlExitOffset;
  assign hit_cnt_en = offset_i == CtrlHwCntEnOffset;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_o      <= 1'b0;
      exit_o      <= '0;
      hw_cnt_en_o <= '0;
    end else begin
      done_o <= req_i;
      if (req_i && write_i) begin
        if (hit_exit)   exit_o      <= strb_merge(exit_o, wdata_i, strb_i);
        if (hit_cnt_en) hw_cnt_en_o <= strb_merge(hw_cnt_en_o, wdata_i, strb_i);
      end
    end
  end

  // Readback, zero data on writes and on unknown offsets
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      err_o   <= ~(hit_exit | hit_cnt_en);
      rdata_o <= '0;
      if (!write_i && hit_exit)   rdata_o <= exit_o;
      if (!write_i && hit_cnt_en) rdata_o <= hw_cnt_en_o;
    end
  end

endmodule

`default_nettype wire

//--- logic/soc_resp_stage.sv
`timescale 1ns/1ps
`default_nettype none

module soc_resp_stage import soc_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  soc_region_e             cmd_region_i,
  input  logic                    none_start_i,
  input  logic                    l2_done_i,
  input  logic [SocDataWidth-1:0] l2_rdata_i,
  input  logic                    uart_done_i,
  input  logic [SocDataWidth-1:0] uart_rdata_i,
  input  logic                    uart_err_i,
  input  logic                    ctrl_done_i,
  input  logic [SocDataWidth-1:0] ctrl_rdata_i,
  input  logic                    ctrl_err_i,
  input  logic                    rsp_ready_i,
  output logic                    rsp_valid_o,
  output logic [SocDataWidth-1:0] rsp_rdata_o,
  output logic                    rsp_error_o,
  output logic                    rsp_taken_o
);

  logic                    done_sel;
  logic [SocDataWidth-1:0] rdata_sel;
  logic                    err_sel;

  // Completion of the region in flight
  always_comb begin
    case (cmd_region_i)
      REGION_L2:   {done_sel, rdata_sel, err_sel} = {l2_done_i, l2_rdata_i, 1'b0};
      REGION_UART: {done_sel, rdata_sel, err_sel} = {uart_done_i, uart_rdata_i, uart_err_i};
      REGION_CTRL: {done_sel, rdata_sel, err_sel} = {ctrl_done_i, ctrl_rdata_i, ctrl_err_i};
      default:     {done_sel, rdata_sel, err_sel} = {none_start_i, {SocDataWidth{1'b0}}, 1'b1};
    endcase
  end

  assign rsp_taken_o = rsp_valid_o & rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i)          rsp_valid_o <= 1'b0;
    else if (done_sel)    rsp_valid_o <= 1'b1;
    else if (rsp_taken_o) rsp_valid_o <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (done_sel) begin
      rsp_rdata_o <= rdata_sel;
      rsp_error_o <= err_sel;
    end
  end

endmodule

`default_nettype wire

//--- logic/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_valid_i,
  input  logic                    req_write_i,
  input  logic [SocAddrWidth-1:0] req_addr_i,
  input  logic [SocDataWidth-1:0] req_wdata_i,
  input  logic [SocStrbWidth-1:0] req_strb_i,
  input  logic                    rsp_ready_i,
  input  logic [ApbDataWidth-1:0] uart_prdata_i,
  input  logic                    uart_pready_i,
  input  logic                    uart_pslverr_i,
  output logic                    req_ready_o,
  output logic                    rsp_valid_o,
  output logic [SocDataWidth-1:0] rsp_rdata_o,
  output logic                    rsp_error_o,
  output logic [63:0]             exit_o,
  output logic [63:0]             hw_cnt_en_o,
  output logic                    uart_psel_o,
  output logic                    uart_penable_o,
  output logic                    uart_pwrite_o,
  output logic [31:0]             uart_paddr_o,
  output logic [ApbDataWidth-1:0] uart_pwdata_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  soc_region_e             cmd_region;
  logic                    cmd_write;
  logic [SocAddrWidth-1:0] cmd_offset;
  logic [SocDataWidth-1:0] cmd_wdata;
  logic [SocStrbWidth-1:0] cmd_strb;
  logic                    l2_req, uart_req, ctrl_req, none_start;
  logic                    rsp_taken;

  soc_addr_decode i_decode (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_strb_i  (req_strb_i),
    .rsp_taken_i (rsp_taken),
    .req_ready_o (req_ready_o),
    .cmd_region_o(cmd_region),
    .cmd_write_o (cmd_write),
    .cmd_offset_o(cmd_offset),
    .cmd_wdata_o (cmd_wdata),
    .cmd_strb_o  (cmd_strb),
    .l2_req_o    (l2_req),
    .uart_req_o  (uart_req),
    .ctrl_req_o  (ctrl_req),
    .none_start_o(none_start)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Targets
  ////////////////////////////////////////////////////////////////////////////

  logic                    l2_done, uart_done, ctrl_done;
  logic [SocDataWidth-1:0] l2_rdata, uart_rdata, ctrl_rdata;
  logic                    uart_err, ctrl_err;

  l2_mem #(
    .L2NumWords(L2NumWords)
  ) i_l2_mem (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (l2_req),
    .write_i (cmd_write),
    .offset_i(cmd_offset),
    .wdata_i (cmd_wdata),
    .strb_i  (cmd_strb),
    .done_o  (l2_done),
    .rdata_o (l2_rdata)
  );

  apb_uart_bridge i_uart_bridge (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (uart_req),
    .write_i       (cmd_write),
    .offset_i      (cmd_offset),
    .wdata_i       (cmd_wdata),
    .uart_prdata_i (uart_prdata_i),
    .uart_pready_i (uart_pready_i),
    .uart_pslverr_i(uart_pslverr_i),
    .done_o        (uart_done),
    .rdata_o       (uart_rdata),
    .err_o         (uart_err),
    .uart_psel_o   (uart_psel_o),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o),
    .uart_paddr_o  (uart_paddr_o),
    .uart_pwdata_o (uart_pwdata_o)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (ctrl_req),
    .write_i    (cmd_write),
    .offset_i   (cmd_offset),
    .wdata_i    (cmd_wdata),
    .strb_i     (cmd_strb),
    .done_o     (ctrl_done),
    .rdata_o    (ctrl_rdata),
    .err_o      (ctrl_err),
    .exit_o     (exit_o),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

  // Response path
  soc_resp_stage i_resp_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_region_i(cmd_region),
    .none_start_i(none_start),
    .l2_done_i   (l2_done),
    .l2_rdata_i  (l2_rdata),
    .uart_done_i (uart_done),
    .uart_rdata_i(uart_rdata),
    .uart_err_i  (uart_err),
    .ctrl_done_i (ctrl_done),
    .ctrl_rdata_i(ctrl_rdata),
    .ctrl_err_i  (ctrl_err),
    .rsp_ready_i (rsp_ready_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_error_o (rsp_error_o),
    .rsp_taken_o (rsp_taken)
  );

endmodule

`default_nettype wire

//--- test/soc_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module soc_asserts import soc_pkg::*; (
  input logic        clk_i,
  input logic        reset_i,
  input logic        uart_psel_o,
  input logic        uart_penable_o,
  input logic        rsp_valid_o,
  input logic        rsp_ready_i,
  input logic [63:0] rsp_rdata_o,
  input logic        rsp_error_o,
  input logic        req_ready_o,
  input logic        l2_req,
  input logic        uart_req,
  input logic        ctrl_req,
  input logic        none_start,
  input logic        cmd_write,
  input logic [63:0] cmd_offset,
  input logic [63:0] exit_o,
  input logic [63:0] hw_cnt_en_o
);

  penable_needs_psel: assert property (@(posedge clk_i) disable iff (reset_i)
    uart_penable_o |-> uart_psel_o)
    else $error("APB penable high while psel is low");

  // Stalled response keeps its payload
  rsp_held_when_stalled: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_error_o))
    else $error("Response changed while stalled");

  no_accept_during_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o |-> !req_ready_o)
    else $error("req_ready_o high while a response is pending");

  single_start_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({l2_req, uart_req, ctrl_req, none_start}))
    else $error("More than one target start pulse at once");

  // Writes to unknown CTRL offsets touch no register
  ctrl_bad_write_ignored: assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_req && cmd_write && cmd_offset != CtrlExitOffset && cmd_offset != CtrlHwCntEnOffset
    |=> $stable(exit_o) && $stable(hw_cnt_en_o))
    else $error("CTRL write at an unknown offset changed a register");

endmodule

bind soc_top soc_asserts u_asserts (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .uart_psel_o   (uart_psel_o),
  .uart_penable_o(uart_penable_o),
  .rsp_valid_o   (rsp_valid_o),
  .rsp_ready_i   (rsp_ready_i),
  .rsp_rdata_o   (rsp_rdata_o),
  .rsp_error_o   (rsp_error_o),
  .req_ready_o   (req_ready_o),
  .l2_req        (l2_req),
  .uart_req      (uart_req),
  .ctrl_req      (ctrl_req),
  .none_start    (none_start),
  .cmd_write     (cmd_write),
  .cmd_offset    (cmd_offset),
  .exit_o        (exit_o),
  .hw_cnt_en_o   (hw_cnt_en_o)
);

`default_nettype wire

//--- test/tb_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc import soc_pkg::*; ();

  localparam int GoldenMaxLines = 64;
  localparam int Fields         = 7;

  logic        clk_i;
  logic        reset_i;
  logic        req_valid_i;
  logic        req_write_i;
  logic [63:0] req_addr_i;
  logic [63:0] req_wdata_i;
  logic [7:0]  req_strb_i;
  logic        rsp_ready_i;
  logic [31:0] uart_prdata_i;
  logic        uart_pready_i;
  logic        uart_pslverr_i;
  logic        req_ready_o;
  logic        rsp_valid_o;
  logic [63:0] rsp_rdata_o;
  logic        rsp_error_o;
  logic [63:0] exit_o;
  logic [63:0] hw_cnt_en_o;
  logic        uart_psel_o;
  logic        uart_penable_o;
  logic        uart_pwrite_o;
  logic [31:0] uart_paddr_o;
  logic [31:0] uart_pwdata_o;

  logic [63:0] golden [GoldenMaxLines*Fields];
  int          n_lines;
  int          n_checks;
  int          n_errors;
  int          cycle_count;
  int          cycle_limit;

  // APB slave model state
  logic [31:0] apb_regs [4];
  logic [31:0] last_paddr;
  logic [31:0] last_pwdata;
  logic        last_pwrite;

  // Expected CTRL register contents
  logic [63:0] exit_exp;
  logic [63:0] cnt_exp;

  soc_top #(
    .L2NumWords(1024)
  ) u_dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_write_i   (req_write_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .req_strb_i    (req_strb_i),
    .rsp_ready_i   (rsp_ready_i),
    .uart_prdata_i (uart_prdata_i),
    .uart_pready_i (uart_pready_i),
    .uart_pslverr_i(uart_pslverr_i),
    .req_ready_o   (req_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_rdata_o   (rsp_rdata_o),
    .rsp_error_o   (rsp_error_o),
    .exit_o        (exit_o),
    .hw_cnt_en_o   (hw_cnt_en_o),
    .uart_psel_o   (uart_psel_o),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o),
    .uart_paddr_o  (uart_paddr_o),
    .uart_pwdata_o (uart_pwdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Run limit from the golden line count
  initial begin
    cycle_count = 0;
    while (cycle_limit == 0 || cycle_count < cycle_limit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the DUT stopped answering requests", cycle_count);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB slave with random wait states
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int wait_left;
    wait_left      = 0;
    uart_pready_i  = 1'b0;
    uart_prdata_i  = '0;
    uart_pslverr_i = 1'b0;
    last_paddr     = '0;
    last_pwdata    = '0;
    last_pwrite    = 1'b0;
    for (int i = 0; i < 4; i++) begin
      apb_regs[i] = '0;
    end
    forever begin
      @(negedge clk_i);
      uart_pready_i  = 1'b0;
      uart_prdata_i  = '0;
      uart_pslverr_i = 1'b0;
      if (uart_psel_o && !uart_penable_o) begin
        wait_left = int'($urandom % 4);
      end else if (uart_psel_o && uart_penable_o) begin
        if (wait_left > 0) begin
          wait_left--;
        end else begin
          uart_pready_i = 1'b1;
          last_paddr    = uart_paddr_o;
          last_pwdata   = uart_pwdata_o;
          last_pwrite   = uart_pwrite_o;
          if (uart_paddr_o >= 32'h10) begin
            uart_pslverr_i = 1'b1;
          end else if (uart_pwrite_o) begin
            apb_regs[uart_paddr_o[3:2]] = uart_pwdata_o;
          end else begin
            uart_prdata_i = apb_regs[uart_paddr_o[3:2]];
          end
        end
      end
    end
  end

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    n_checks++;
    assert (actual === expected) else begin
      n_errors++;
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, what, expected, actual);
    end
  endtask

  function automatic logic [63:0] apply_strobe(input logic [63:0] old_val,
                                               input logic [63:0] new_val,
                                               input logic [7:0]  strb);
    logic [63:0] mask;
    mask = '0;
    for (int i = 0; i < 8; i++) begin
      mask[i*8 +: 8] = {8{strb[i]}};
    end
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic soc_region_e region_of(input logic [63:0] addr);
    if (addr >= DramBase && addr - DramBase < DramLength) return REGION_L2;
    if (addr >= UartBase && addr - UartBase < UartLength) return REGION_UART;
    if (addr >= CtrlBase && addr - CtrlBase < CtrlLength) return REGION_CTRL;
    return REGION_NONE;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // One golden line: request, latency, stall, response
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_line(input int ln);
    logic [63:0] op;
    logic [63:0] addr;
    logic [63:0] wdata;
    logic [7:0]  strb;
    logic [63:0] exp_rdata;
    logic [63:0] exp_err;
    logic [63:0] offset;
    soc_region_e region;
    int          latency;
    int          stall;
    op        = golden[ln*Fields];
    addr      = golden[ln*Fields+1];
    wdata     = golden[ln*Fields+2];
    strb      = golden[ln*Fields+3][7:0];
    exp_rdata = golden[ln*Fields+4];
    exp_err   = golden[ln*Fields+5];
    region    = region_of(addr);
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_write_i = op[0];
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_strb_i  = strb;
    while (!req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    latency     = 1;
    while (!rsp_valid_o) begin
      @(negedge clk_i);
      latency++;
    end
    if (region == REGION_NONE) begin
      check_value("unmapped latency", 64'd2, 64'(latency));
    end else if (region != REGION_UART) begin
      check_value("target latency", 64'd3, 64'(latency));
    end
    stall = int'($urandom % 4);
    repeat (stall) @(negedge clk_i);
    check_value("rsp_valid_o while stalled", 64'd1, 64'(rsp_valid_o));
    check_value("rsp_rdata_o", exp_rdata, rsp_rdata_o);
    check_value("rsp_error_o", exp_err, 64'(rsp_error_o));
    rsp_ready_i = 1'b1;
    @(negedge clk_i);
    rsp_ready_i = 1'b0;
    check_value("rsp_valid_o after handshake", 64'd0, 64'(rsp_valid_o));
    if (region == REGION_CTRL) begin
      offset = addr - CtrlBase;
      if (op[0] && offset == CtrlExitOffset) exit_exp = apply_strobe(exit_exp, wdata, strb);
      if (op[0] && offset == CtrlHwCntEnOffset) cnt_exp = apply_strobe(cnt_exp, wdata, strb);
      check_value("exit_o", exit_exp, exit_o);
      check_value("hw_cnt_en_o", cnt_exp, hw_cnt_en_o);
    end else if (region == REGION_UART) begin
      offset = addr - UartBase;
      check_value("uart paddr", {32'd0, offset[31:0]}, {32'd0, last_paddr});
      check_value("uart pwdata", {32'd0, wdata[31:0]}, {32'd0, last_pwdata});
      check_value("uart pwrite", 64'(op[0]), 64'(last_pwrite));
    end
  endtask

  initial begin
    int          test_lines;
    int          test_err_start;
    void'($urandom(87411));
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_strb_i  = '0;
    rsp_ready_i = 1'b0;
    exit_exp    = '0;
    cnt_exp     = '0;
    n_checks    = 0;
    n_errors    = 0;
    // Unused entries keep an all-ones op as end marker
    for (int i = 0; i < GoldenMaxLines*Fields; i++) begin
      golden[i] = '1;
    end
    $readmemh("test/soc_golden.txt", golden);
    n_lines = 0;
    while (n_lines < GoldenMaxLines && golden[n_lines*Fields] != '1) n_lines++;
    if (n_lines == 0) begin
      $display("The golden file held no request lines");
      n_errors++;
    end
    cycle_limit = n_lines * 20 + 50;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    check_value("req_ready_o after reset", 64'd1, 64'(req_ready_o));
    check_value("rsp_valid_o after reset", 64'd0, 64'(rsp_valid_o));
    check_value("uart_psel_o after reset", 64'd0, 64'(uart_psel_o));
    check_value("uart_penable_o after reset", 64'd0, 64'(uart_penable_o));
    check_value("exit_o after reset", 64'd0, exit_o);
    check_value("hw_cnt_en_o after reset", 64'd0, hw_cnt_en_o);
    $display("Test 6 finished: reset state, %0d errors", n_errors);

    test_lines     = 0;
    test_err_start = n_errors;
    for (int ln = 0; ln < n_lines; ln++) begin
      run_line(ln);
      test_lines++;
      if (ln == n_lines - 1 || golden[(ln+1)*Fields+6] != golden[ln*Fields+6]) begin
        $display("Test %0d finished: %0d lines, %0d errors", int'(golden[ln*Fields+6]),
                 test_lines, n_errors - test_err_start);
        test_lines     = 0;
        test_err_start = n_errors;
      end
    end

    $display("Checks: %0d run, %0d failed", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/soc_golden.txt
// op addr wdata strb exp_rdata exp_err test, all in hex
// op 1 is a write and 0 a read, exp_rdata is zero for writes
1 80000000 1122334455667788 ff 0000000000000000 0 1
1 80000000 aaaaaaaaaaaaaaaa 0f 0000000000000000 0 1
0 80000000 0000000000000000 00 11223344aaaaaaaa 0 1
1 80000100 ffeeddccbbaa9988 ff 0000000000000000 0 1
1 80000100 0000000000000000 81 0000000000000000 0 1
0 80000100 0000000000000000 00 00eeddccbbaa9900 0 1
0 80002000 0000000000000000 00 11223344aaaaaaaa 0 1
1 d0000000 0000000000000001 01 0000000000000000 0 2
0 d0000000 0000000000000000 00 0000000000000001 0 2
1 d0000008 00000000deadbeef 03 0000000000000000 0 2
0 d0000008 0000000000000000 00 000000000000beef 0 2
1 d0000010 0000000000001234 ff 0000000000000000 1 2
0 d0000004 0000000000000000 00 0000000000000000 1 2
1 c0000004 cafef00d12345678 ff 0000000000000000 0 3
0 c0000004 0000000000000000 00 0000000012345678 0 3
1 c000000c 00000000a5a5a5a5 ff 0000000000000000 0 3
0 c000000c 0000000000000000 00 00000000a5a5a5a5 0 3
0 c0000010 0000000000000000 00 0000000000000000 1 3
1 c0000ff0 0000000000000001 ff 0000000000000000 1 3
0 00001000 0000000000000000 00 0000000000000000 1 4
1 c0001000 0000000000000055 ff 0000000000000000 1 4
0 f0000000 0000000000000000 00 0000000000000000 1 4
0 80000000 0000000000000000 00 11223344aaaaaaaa 0 5
0 d0000000 0000000000000000 00 0000000000000001 0 5
0 c0000004 0000000000000000 00 0000000012345678 0 5

//--- flist.f
logic/soc_pkg.sv
logic/soc_addr_decode.sv
logic/l2_mem.sv
logic/apb_uart_bridge.sv
logic/ctrl_regs.sv
logic/soc_resp_stage.sv
logic/soc_top.sv
test/soc_asserts.sv
test/tb_soc.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the SoC testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_soc -f flist.f -o sim_soc

./obj_dir/sim_soc 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation reported failing checks"
  exit 1
fi
echo "Simulation finished without failing checks"
